/* verilog/rvPkg.sv */
package rvPkg;

	typedef logic [31:0] word_t;    // data, instruction or pc
	typedef logic [4:0]  regAddr_t;
	typedef logic [11:0] memAddr_t; // external memory port address
	typedef logic [3:0]  byteEn_t;

	// RV32I major opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	// li x1,12 then ret ends the program
	localparam word_t HALT_PREV = 32'h00c00093;
	localparam word_t HALT_CURR = 32'h00008067;

	// funct3 of loads and stores
	localparam logic [2:0] MEM_B  = 3'b000;
	localparam logic [2:0] MEM_H  = 3'b001;
	localparam logic [2:0] MEM_W  = 3'b010;
	localparam logic [2:0] MEM_BU = 3'b100;
	localparam logic [2:0] MEM_HU = 3'b101;

	typedef enum logic [4:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASSB,
		// branch compares, result in bit 0
		ALU_EQ,
		ALU_NE,
		ALU_LT,
		ALU_GE,
		ALU_LTU,
		ALU_GEU
	} aluOp_t;

	typedef struct packed {
		aluOp_t     aluOp;
		logic       useImm;   // operand b from immediate
		logic       usePc;    // operand a from pc
		logic       zeroA;    // operand a forced to zero
		logic       isLoad;
		logic       isStore;
		logic       isBranch;
		logic       isJal;
		logic       isJalr;
		logic       regWrite;
		logic [2:0] memFunct; // width and sign of access
	} decodeCtrl_t;

endpackage

/* verilog/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder import rvPkg::*; (
	input  word_t       instr,
	output decodeCtrl_t ctrl,
	output word_t       imm,
	output regAddr_t    rfRa1,
	output regAddr_t    rfRa2,
	output regAddr_t    rfWa1
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       funct7b5;
	logic       writesRd;

	assign opcode   = instr[6:0];
	assign funct3   = instr[14:12];
	assign funct7b5 = instr[30];

	assign rfRa1 = instr[19:15];
	assign rfRa2 = instr[24:20];
	assign rfWa1 = instr[11:7];

	// alt selects sub or sra
	function automatic aluOp_t aluFromFunct(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	function automatic aluOp_t branchOp(input logic [2:0] f3);
		case (f3)
			3'b000:  return ALU_EQ;
			3'b001:  return ALU_NE;
			3'b100:  return ALU_LT;
			3'b101:  return ALU_GE;
			3'b110:  return ALU_LTU;
			default: return ALU_GEU;
		endcase
	endfunction

	always_comb begin
		ctrl          = '0;
		ctrl.aluOp    = ALU_ADD;
		ctrl.memFunct = funct3;
		writesRd      = 1'b0;
		imm           = {{20{instr[31]}}, instr[31:20]}; // I type by default
		case (opcode)
			OPC_LUI: begin
				ctrl.zeroA  = 1'b1;
				ctrl.useImm = 1'b1;
				writesRd    = 1'b1;
				imm         = {instr[31:12], 12'b0};
			end
			OPC_AUIPC: begin
				ctrl.usePc  = 1'b1;
				ctrl.useImm = 1'b1;
				writesRd    = 1'b1;
				imm         = {instr[31:12], 12'b0};
			end
			OPC_JAL: begin
				ctrl.aluOp  = ALU_PASSB; // result unused, target is pc + imm
				ctrl.useImm = 1'b1;
				ctrl.isJal  = 1'b1;
				writesRd    = 1'b1;
				imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			end
			OPC_JALR: begin
				ctrl.useImm = 1'b1;
				ctrl.isJalr = 1'b1;
				writesRd    = 1'b1;
			end
			OPC_BRANCH: begin
				ctrl.aluOp    = branchOp(funct3);
				ctrl.isBranch = 1'b1;
				imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			end
			OPC_LOAD: begin
				ctrl.useImm = 1'b1;
				ctrl.isLoad = 1'b1;
				writesRd    = 1'b1;
			end
			OPC_STORE: begin
				ctrl.useImm  = 1'b1;
				ctrl.isStore = 1'b1;
				imm          = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
			OPC_OPIMM: begin
				// only srai uses funct7 here
				ctrl.aluOp  = aluFromFunct(funct3, funct7b5 && (funct3 == 3'b101));
				ctrl.useImm = 1'b1;
				writesRd    = 1'b1;
			end
			OPC_OP: begin
				ctrl.aluOp = aluFromFunct(funct3, funct7b5);
				writesRd   = 1'b1;
			end
			default: ;
		endcase
		ctrl.regWrite = writesRd && (rfWa1 != 5'd0); // x0 never written
	end

endmodule

/* verilog/execUnit.sv */
`timescale 1ns/1ps

module execUnit import rvPkg::*; (
	input  decodeCtrl_t ctrl,
	input  word_t       rd1,
	input  word_t       rd2,
	input  word_t       pc,
	input  word_t       imm,
	output word_t       aluResult,
	output logic        branchTaken
);

	word_t       opA;
	word_t       opB;
	logic [4:0]  shamt;

	always_comb begin
		if (ctrl.zeroA)
			opA = '0;
		else if (ctrl.usePc)
			opA = pc;
		else
			opA = rd1;
	end

	assign opB   = ctrl.useImm ? imm : rd2;
	assign shamt = opB[4:0];

	always_comb begin
		case (ctrl.aluOp)
			ALU_ADD:   aluResult = opA + opB;
			ALU_SUB:   aluResult = opA - opB;
			ALU_SLL:   aluResult = opA << shamt;
			ALU_SLT:   aluResult = {31'b0, $signed(opA) < $signed(opB)};
			ALU_SLTU:  aluResult = {31'b0, opA < opB};
			ALU_XOR:   aluResult = opA ^ opB;
			ALU_SRL:   aluResult = opA >> shamt;
			ALU_SRA:   aluResult = word_t'($signed(opA) >>> shamt);
			ALU_OR:    aluResult = opA | opB;
			ALU_AND:   aluResult = opA & opB;
			ALU_PASSB: aluResult = opB;
			ALU_EQ:    aluResult = {31'b0, opA == opB};
			ALU_NE:    aluResult = {31'b0, opA != opB};
			ALU_LT:    aluResult = {31'b0, $signed(opA) < $signed(opB)};
			ALU_GE:    aluResult = {31'b0, $signed(opA) >= $signed(opB)};
			ALU_LTU:   aluResult = {31'b0, opA < opB};
			ALU_GEU:   aluResult = {31'b0, opA >= opB};
			default:   aluResult = '0;
		endcase
	end

	// compare ops leave the outcome in bit 0
	assign branchTaken = ctrl.isBranch & aluResult[0];

endmodule

/* verilog/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit import rvPkg::*; (
	input  logic        CLK,
	input  logic        RSTn,
	input  word_t       instr,
	input  decodeCtrl_t ctrl,
	input  word_t       imm,
	input  word_t       aluResult,
	input  logic        branchTaken,
	output word_t       pc,
	output logic        halt
);

	word_t prevInstr;  // instruction of the last completed cycle
	word_t pcPlus4;
	word_t pcPlusImm;
	word_t nextPc;
	logic  haltSticky;
	logic  haltDetect;

	assign pcPlus4   = pc + 32'd4;
	assign pcPlusImm = pc + imm;

	always_comb begin
		if (ctrl.isJalr)
			nextPc = {aluResult[31:1], 1'b0};
		else if (ctrl.isJal || branchTaken)
			nextPc = pcPlusImm;
		else
			nextPc = pcPlus4;
	end

	// seen as soon as the second word of the sequence is fetched
	assign haltDetect = (prevInstr == HALT_PREV) && (instr == HALT_CURR);
	assign halt       = haltSticky | haltDetect;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc         <= '0;
			prevInstr  <= '0;
			haltSticky <= 1'b0;
		end else begin
			haltSticky <= halt;
			if (!halt) begin // frozen once halted
				pc        <= nextPc;
				prevInstr <= instr;
			end
		end
	end

endmodule

/* verilog/memAccessUnit.sv */
`timescale 1ns/1ps

module memAccessUnit import rvPkg::*; (
	input  decodeCtrl_t ctrl,
	input  word_t       addr,
	input  word_t       storeData,
	input  word_t       memRdata,
	output memAddr_t    memAddr,
	output word_t       memWdata,
	output byteEn_t     memBe,
	output logic        memWen,
	output word_t       loadData
);

	logic [1:0] byteOff;
	word_t      shifted;

	assign byteOff = addr[1:0];
	assign memAddr = addr[13:2]; // byte to word address
	assign memWen  = ctrl.isStore;

	// lanes are picked by memBe, so data is replicated
	always_comb begin
		case (ctrl.memFunct[1:0])
			2'b00: begin
				memWdata = {4{storeData[7:0]}};
				memBe    = byteEn_t'(4'b0001 << byteOff);
			end
			2'b01: begin
				memWdata = {2{storeData[15:0]}};
				memBe    = byteOff[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				memWdata = storeData;
				memBe    = 4'b1111;
			end
		endcase
	end

	assign shifted = memRdata >> {byteOff, 3'b000};

	always_comb begin
		case (ctrl.memFunct)
			MEM_B:   loadData = {{24{shifted[7]}}, shifted[7:0]};
			MEM_H:   loadData = {{16{shifted[15]}}, shifted[15:0]};
			MEM_W:   loadData = memRdata;
			MEM_BU:  loadData = {24'b0, shifted[7:0]};
			MEM_HU:  loadData = {16'b0, shifted[15:0]};
			default: loadData = memRdata;
		endcase
	end

endmodule

/* verilog/riscvTop.sv */
`timescale 1ns/1ps

module riscvTop import rvPkg::*; (
	input  logic     CLK,
	input  logic     RSTn,      // high holds the core in reset

	// instruction memory
	output logic     iMemCsn,
	input  word_t    iMemData,
	output memAddr_t iMemAddr,  // byte address

	// data memory
	output logic     dMemCsn,
	input  word_t    dMemData,
	output word_t    dMemDout,
	output memAddr_t dMemAddr,  // word address
	output logic     dMemWen,
	output byteEn_t  dMemBe,

	// register file
	output logic     rfWe,
	output regAddr_t rfRa1,
	output regAddr_t rfRa2,
	output regAddr_t rfWa1,
	input  word_t    rfRd1,
	input  word_t    rfRd2,
	output word_t    rfWd,

	output logic     halt,
	output word_t    numInst,   // completed instructions
	output word_t    outputPort
);

	decodeCtrl_t ctrl;
	word_t       imm;
	word_t       pc;
	word_t       pcPlus4;
	word_t       aluResult;
	word_t       loadData;
	logic        branchTaken;
	logic        memWen;
	logic        active;

	assign active = !RSTn && !halt;

	instrDecoder u_instrDecoder (
		.instr (iMemData),
		.ctrl  (ctrl),
		.imm   (imm),
		.rfRa1 (rfRa1),
		.rfRa2 (rfRa2),
		.rfWa1 (rfWa1)
	);

	fetchUnit u_fetchUnit (
		.CLK         (CLK),
		.RSTn        (RSTn),
		.instr       (iMemData),
		.ctrl        (ctrl),
		.imm         (imm),
		.aluResult   (aluResult),
		.branchTaken (branchTaken),
		.pc          (pc),
		.halt        (halt)
	);

	execUnit u_execUnit (
		.ctrl        (ctrl),
		.rd1         (rfRd1),
		.rd2         (rfRd2),
		.pc          (pc),
		.imm         (imm),
		.aluResult   (aluResult),
		.branchTaken (branchTaken)
	);

	memAccessUnit u_memAccessUnit (
		.ctrl      (ctrl),
		.addr      (aluResult),
		.storeData (rfRd2),
		.memRdata  (dMemData),
		.memAddr   (dMemAddr),
		.memWdata  (dMemDout),
		.memBe     (dMemBe),
		.memWen    (memWen),
		.loadData  (loadData)
	);

	assign iMemAddr = pc[11:0];
	assign iMemCsn  = RSTn; // chip selects are active low
	assign dMemCsn  = RSTn;

	// writeback select, link address for jumps
	assign pcPlus4 = pc + 32'd4;
	always_comb begin
		if (ctrl.isJal || ctrl.isJalr)
			rfWd = pcPlus4;
		else if (ctrl.isLoad)
			rfWd = loadData;
		else
			rfWd = aluResult;
	end

	assign rfWe       = ctrl.regWrite & active;
	assign dMemWen    = memWen & active;
	assign outputPort = rfWd;

	always_ff @(posedge CLK) begin
		if (RSTn)
			numInst <= '0;
		else if (!halt)
			numInst <= numInst + 32'd1;
	end

endmodule

/* testbench/riscvTop_assertions.sv */
`timescale 1ns/1ps

module riscvTopAssertions import rvPkg::*; (
	input logic  CLK,
	input logic  RSTn,
	input logic  iMemCsn,
	input logic  dMemCsn,
	input logic  rfWe,
	input logic  dMemWen,
	input logic  halt,
	input word_t pc,
	input word_t numInst,
	input word_t rfWd,
	input word_t outputPort
);

	int failCount = 0; // failed assertions so far

	// memories deselected and nothing written while in reset
	resetQuiet: assert property (@(posedge CLK)
		RSTn |-> (!rfWe && !dMemWen && iMemCsn && dMemCsn))
		else begin
			failCount++;
			$error("write enable or chip select active during reset");
		end

	pcAligned: assert property (@(posedge CLK) disable iff (RSTn) pc[1:0] == 2'b00)
		else begin
			failCount++;
			$error("pc not word aligned");
		end

	haltNoWrite: assert property (@(posedge CLK) halt |-> (!rfWe && !dMemWen))
		else begin
			failCount++;
			$error("write while halted");
		end

	// counter and pc frozen after halt
	haltFrozen: assert property (@(posedge CLK) disable iff (RSTn)
		halt |=> ($stable(numInst) && $stable(pc)))
		else begin
			failCount++;
			$error("numInst or pc moved while halted");
		end

	portMatch: assert property (@(posedge CLK) outputPort == rfWd)
		else begin
			failCount++;
			$error("outputPort differs from rfWd");
		end

endmodule

bind riscvTop riscvTopAssertions u_riscvTopAssertions (
	.CLK(CLK), .RSTn(RSTn), .iMemCsn(iMemCsn), .dMemCsn(dMemCsn), .rfWe(rfWe),
	.dMemWen(dMemWen), .halt(halt), .pc(pc), .numInst(numInst), .rfWd(rfWd),
	.outputPort(outputPort)
);

/* testbench/riscvTop_tb.sv */
`timescale 1ns/1ps

module riscvTop_tb import rvPkg::*; ();

	localparam int RESET_CYCLES = 10;
	localparam int MARGIN       = 64;

	logic CLK, RSTn, iMemCsn, dMemCsn, dMemWen, rfWe, halt;
	word_t iMemData, dMemData, dMemDout, rfRd1, rfRd2, rfWd, numInst, outputPort;
	memAddr_t iMemAddr, dMemAddr;
	byteEn_t dMemBe;
	regAddr_t rfRa1, rfRa2, rfWa1;

	word_t rom [0:1023];
	word_t ram [0:4095];
	word_t regs [0:31];
	word_t expReg [0:31];
	int progLen = 0;
	int cycles = 0;
	int limit = 1000;

	riscvTop u_riscvTop (.*);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// combinational reads with x0 hardwired to zero
	assign iMemData = rom[iMemAddr[11:2]];
	assign dMemData = ram[dMemAddr];
	assign rfRd1 = (rfRa1 == 5'd0) ? 32'd0 : regs[rfRa1];
	assign rfRd2 = (rfRa2 == 5'd0) ? 32'd0 : regs[rfRa2];

	always @(posedge CLK) begin
		if (rfWe && rfWa1 != 5'd0)
			regs[rfWa1] <= rfWd;
		if (dMemWen && !dMemCsn)
			for (int b = 0; b < 4; b++)
				if (dMemBe[b])
					ram[dMemAddr][b*8 +: 8] <= dMemDout[b*8 +: 8];
	end

	// timeout and assertion watch
	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("timeout: halt not reached within %0d cycles", limit);
			$display("tests failed");
			$fatal(1, "timeout");
		end else if (u_riscvTop.u_riscvTopAssertions.failCount != 0) begin
			$display("an assertion on riscvTop failed at %0t", $time);
			$display("tests failed");
			$fatal(1, "assertion failure");
		end
	end

	function automatic word_t encI(logic [11:0] imm, regAddr_t rs1, logic [2:0] f3,
			regAddr_t rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t encR(logic [6:0] f7, regAddr_t rs2, regAddr_t rs1,
			logic [2:0] f3, regAddr_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic word_t encS(logic [11:0] imm, regAddr_t rs2, regAddr_t rs1,
			logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic word_t encB(logic [12:0] imm, regAddr_t rs2, regAddr_t rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic word_t encJ(logic [20:0] imm, regAddr_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	task automatic emit(input word_t w);
		rom[progLen] = w;
		progLen++;
	endtask

	task automatic checkValue(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			$display("tests failed");
			$fatal(1, "mismatch");
		end
	endtask

	initial begin
		word_t haltPc;
		RSTn = 1'b1;
		for (int i = 0; i < 1024; i++)
			rom[i] = encI(i[11:0], 5'd0, 3'b000, 5'd0, OPC_OPIMM); // nop whose imm is the index
		for (int i = 0; i < 4096; i++)
			ram[i] = 32'hA5000000 ^ i;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
			expReg[i] = '0;
		end
		// arithmetic and immediates
		emit(encI(12'd5, 5'd0, 3'b000, 5'd1, OPC_OPIMM));
		emit(encI(-12'sd3, 5'd0, 3'b000, 5'd2, OPC_OPIMM));
		emit({20'h12345, 5'd3, OPC_LUI});
		emit({20'h00001, 5'd4, OPC_AUIPC});                 // pc 12
		emit(encI(12'd3, 5'd1, 3'b001, 5'd5, OPC_OPIMM));   // slli
		emit(encI(12'h401, 5'd2, 3'b101, 5'd6, OPC_OPIMM)); // srai
		emit(encI(12'd28, 5'd2, 3'b101, 5'd7, OPC_OPIMM));  // srli
		emit(encR(7'd0, 5'd1, 5'd2, 3'b010, 5'd8));          // slt
		emit(encR(7'd0, 5'd1, 5'd2, 3'b011, 5'd9));          // sltu
		emit(encR(7'd0, 5'd2, 5'd1, 3'b100, 5'd10));
		emit(encR(7'd0, 5'd3, 5'd1, 3'b110, 5'd11));
		emit(encR(7'd0, 5'd3, 5'd2, 3'b111, 5'd12));
		emit(encR(7'h20, 5'd2, 5'd1, 3'b000, 5'd13));       // sub
		// loads and stores around byte 256
		emit(encI(12'h100, 5'd0, 3'b000, 5'd14, OPC_OPIMM));
		emit(encS(12'd0, 5'd3, 5'd14, MEM_W));
		emit(encS(12'd4, 5'd2, 5'd14, MEM_B));
		emit(encS(12'd6, 5'd2, 5'd14, MEM_H));
		emit(encI(12'd4, 5'd14, MEM_B, 5'd15, OPC_LOAD));
		emit(encI(12'd4, 5'd14, MEM_BU, 5'd16, OPC_LOAD));
		emit(encI(12'd6, 5'd14, MEM_H, 5'd17, OPC_LOAD));
		emit(encI(12'd6, 5'd14, MEM_HU, 5'd18, OPC_LOAD));
		emit(encI(12'd0, 5'd14, MEM_W, 5'd19, OPC_LOAD));
		// control flow where x20 must never be written
		emit(encB(13'd8, 5'd1, 5'd1, 3'b000));              // beq taken at pc 88
		emit(encI(12'd1, 5'd0, 3'b000, 5'd20, OPC_OPIMM));
		emit(encB(13'd8, 5'd1, 5'd1, 3'b001));              // bne not taken
		emit(encI(12'd2, 5'd0, 3'b000, 5'd21, OPC_OPIMM));
		emit(encB(13'd8, 5'd1, 5'd2, 3'b100));              // blt taken
		emit(encI(12'd3, 5'd0, 3'b000, 5'd20, OPC_OPIMM));
		emit(encB(13'd8, 5'd1, 5'd2, 3'b111));              // bgeu taken
		emit(encI(12'd4, 5'd0, 3'b000, 5'd20, OPC_OPIMM));
		emit(encJ(21'd12, 5'd22));                          // jal at pc 120
		emit(encI(12'd5, 5'd0, 3'b000, 5'd20, OPC_OPIMM));
		emit(encI(12'd6, 5'd0, 3'b000, 5'd20, OPC_OPIMM));
		emit(encI(12'd148, 5'd0, 3'b000, 5'd23, OPC_OPIMM));
		emit(encI(12'd0, 5'd23, 3'b000, 5'd24, OPC_JALR));  // jalr at pc 136
		emit(encI(12'd7, 5'd0, 3'b000, 5'd20, OPC_OPIMM));
		emit(encI(12'd8, 5'd0, 3'b000, 5'd20, OPC_OPIMM));
		emit(HALT_PREV);                                    // pc 148
		emit(HALT_CURR);
		limit = RESET_CYCLES + progLen + MARGIN;

		expReg[1] = 32'd12;
		expReg[2] = 32'hFFFFFFFD;
		expReg[3] = 32'h12345000;
		expReg[4] = 32'h0000100C;
		expReg[5] = 32'd40;
		expReg[6] = 32'hFFFFFFFE;
		expReg[7] = 32'h0000000F;
		expReg[8] = 32'd1;
		expReg[10] = 32'hFFFFFFF8;
		expReg[11] = 32'h12345005;
		expReg[12] = 32'h12345000;
		expReg[13] = 32'd8;
		expReg[14] = 32'd256;
		expReg[15] = 32'hFFFFFFFD;
		expReg[16] = 32'h000000FD;
		expReg[17] = 32'hFFFFFFFD;
		expReg[18] = 32'h0000FFFD;
		expReg[19] = 32'h12345000;
		expReg[21] = 32'd2;
		expReg[22] = 32'd124;
		expReg[23] = 32'd148;
		expReg[24] = 32'd140;

		repeat (RESET_CYCLES) @(posedge CLK);
		RSTn <= 1'b0;
		@(negedge CLK);
		while (!halt)
			@(negedge CLK);
		haltPc = u_riscvTop.pc;
		repeat (5) @(negedge CLK);

		checkValue("halt", {31'b0, halt}, 32'd1);
		checkValue("pc", u_riscvTop.pc, haltPc);
		checkValue("pc", haltPc, 32'd152);
		checkValue("numInst", numInst, 32'd31); // 31 on the taken path
		for (int i = 1; i < 32; i++)
			checkValue($sformatf("x%0d", i), regs[i], expReg[i]);
		checkValue("ram[64]", ram[64], 32'h12345000);
		checkValue("ram[65]", ram[65], 32'hFFFD00FD);

		if (u_riscvTop.u_riscvTopAssertions.failCount == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("tests failed");
			$fatal(1, "assertion failure in the last cycles");
		end
	end

endmodule

/* rv32Core.f */
verilog/rvPkg.sv
verilog/instrDecoder.sv
verilog/execUnit.sv
verilog/fetchUnit.sv
verilog/memAccessUnit.sv
verilog/riscvTop.sv
testbench/riscvTop_assertions.sv
testbench/riscvTop_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --assert -j 0 -Wno-fatal
TOP      = riscvTop_tb
FILELIST = rv32Core.f
SIMFLAGS = +verilator+error+limit+100
OBJDIR   = obj_dir
LOG      = sim.log
PASS     = all tests passed

.PHONY: help test clean

help:
	@echo "make test   build and run the simulation, check the log"
	@echo "make clean  remove build output and log"
	@echo "make help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
